// ==== files.f ====
logic/icache_pkg.sv
logic/icache_array.sv
logic/icache_refill.sv
logic/icache_ctrl.sv
logic/icache_top.sv
tb/icache_properties.sv
tb/tb_mem_responder.sv
tb/tb_icache.sv

// ==== Makefile ====
# Verilator flow for the instruction cache testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing --assert
TOP       := tb_icache
FILELIST  := files.f
OBJ_DIR   := obj_dir
PASS_MSG  := test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass message shows up as a line of its own
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_icache.sv ====
/* Checks a 16-line cache against a tag and valid model with LFSR seed 70.
   Refill data is the word's byte address XOR data_xor. */
`default_nettype none

module tb_icache;

  import icache_pkg::*;

  localparam int          lines      = 16;
  localparam logic [31:0] data_xor   = 32'h5a3c_96e1;
  localparam int          wait_limit = 200;

  logic        clk;
  logic        rstn;
  logic        core_req;
  logic [31:0] core_addr;
  logic        core_wait;
  word_t       core_out;
  logic        mem_req;
  logic [31:0] mem_addr;
  logic        mem_valid;
  word_t       mem_data;
  logic [31:0] perf_reqs;
  logic [31:0] perf_hits;
  logic [31:0] perf_misses;

  logic [15:0] lfsr;
  line_addr_t  model_tag [lines];
  logic        model_valid [lines];
  int          exp_reqs;
  int          exp_hits;
  int          exp_misses;
  int          checks;
  int          errors;
  logic        aborted;

  icache_top #(.lines(lines)) i_dut (
    .clk        (clk),
    .rstn       (rstn),
    .core_req   (core_req),
    .core_addr  (core_addr),
    .core_wait  (core_wait),
    .core_out   (core_out),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_valid  (mem_valid),
    .mem_data   (mem_data),
    .perf_reqs  (perf_reqs),
    .perf_hits  (perf_hits),
    .perf_misses(perf_misses)
  );

  tb_mem_responder #(.data_xor(data_xor)) i_mem (
    .clk      (clk),
    .rstn     (rstn),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .mem_valid(mem_valid),
    .mem_data (mem_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Fibonacci LFSR with taps 16 14 13 11 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // ========================================
  // One fetch against the model
  // ========================================
  task automatic fetch_and_check(input logic [31:0] addr);
    line_addr_t  line;
    int          idx;
    logic        exp_hit;
    word_t       exp_word;
    logic [31:0] exp_mem_addr;
    int          cycles;
    int          line_reqs;
    line         = addr[31:4];
    idx          = int'(line[$clog2(lines)-1:0]);
    exp_hit      = model_valid[idx] && (model_tag[idx] == line);
    exp_word     = {addr[31:2], 2'b00} ^ data_xor;
    exp_mem_addr = {addr[31:4], 4'h0};
    exp_reqs++;
    if (exp_hit) begin
      exp_hits++;
    end else begin
      exp_misses++;
      model_valid[idx] = 1'b1;
      model_tag[idx]   = line;
    end
    core_req  = 1'b1;
    core_addr = addr;
    @(negedge clk);
    core_req  = 1'b0;
    cycles    = 1;
    line_reqs = 0;
    checks++;
    if (core_wait !== 1'b1) begin
      $display("Fail at %0t: core_wait expected 1 got %b after request for %h",
               $time, core_wait, addr);
      errors++;
    end
    while (core_wait && cycles < wait_limit) begin
      if (mem_req) begin
        line_reqs++;
        checks++;
        if (mem_addr !== exp_mem_addr) begin
          $display("Fail at %0t: mem_addr expected %h got %h",
                   $time, exp_mem_addr, mem_addr);
          errors++;
        end
      end
      @(negedge clk);
      cycles++;
    end
    if (core_wait) begin
      $display("Timeout at %0t: fetch of %h still waiting after %0d cycles",
               $time, addr, cycles);
      errors++;
      aborted = 1'b1;
    end else begin
      checks += 4;
      if (core_out !== exp_word) begin
        $display("Fail at %0t: core_out expected %h got %h for address %h",
                 $time, exp_word, core_out, addr);
        errors++;
      end
      if (exp_hit && cycles != 2) begin
        $display("Fail at %0t: hit latency expected 2 got %0d for address %h",
                 $time, cycles, addr);
        errors++;
      end
      if (line_reqs != (exp_hit ? 0 : 1)) begin
        $display("Fail at %0t: mem_req pulses expected %0d got %0d for address %h",
                 $time, exp_hit ? 0 : 1, line_reqs, addr);
        errors++;
      end
      if (perf_misses !== 32'(exp_misses) || perf_hits !== 32'(exp_hits)) begin
        $display("Fail at %0t: perf_hits/perf_misses expected %0d/%0d got %0d/%0d",
                 $time, exp_hits, exp_misses, perf_hits, perf_misses);
        errors++;
      end
    end
  endtask

  task automatic report_test(input string name, input int fetches, input int errs_before);
    $display("%-18s %0d fetches, %0d errors", name, fetches, errors - errs_before);
  endtask

  // ========================================
  // Tests
  // ========================================
  task automatic fill_all_lines();
    int start;
    start = errors;
    for (int i = 0; i < lines; i++) begin
      if (!aborted) begin
        fetch_and_check(32'h0000_2000 + 32'(i * 16) + 32'(4 * (i % 4)));
      end
    end
    report_test("fill_all_lines", lines, start);
  endtask

  task automatic reread_resident();
    int start;
    start = errors;
    for (int i = 0; i < lines; i++) begin
      if (!aborted) begin
        fetch_and_check(32'h0000_2000 + 32'(i * 16) + 32'(4 * ((i + 1) % 4)));
      end
    end
    report_test("reread_resident", lines, start);
  endtask

  // Lines 0x204 and 0x304 share index 4
  task automatic evict_same_index();
    logic [31:0] seq [5];
    int          start;
    seq   = '{32'h0000_3044, 32'h0000_2048, 32'h0000_304c, 32'h0000_3040, 32'h0000_2044};
    start = errors;
    foreach (seq[i]) begin
      if (!aborted) begin
        fetch_and_check(seq[i]);
      end
    end
    report_test("evict_same_index", 5, start);
  endtask

  task automatic random_fetches(input int n);
    logic [31:0] addr;
    int          start;
    start = errors;
    for (int i = 0; i < n; i++) begin
      // Mostly a 2 KB window so that tags collide and lines get reused
      if (rand_bits(3) != 0) begin
        addr = 32'h0000_4000 + rand_bits(11);
      end else begin
        addr = rand_bits(32);
      end
      if (rand_bits(1) == 1) begin
        @(negedge clk);
      end
      if (!aborted) begin
        fetch_and_check(addr);
      end
    end
    report_test("random_fetches", n, start);
  endtask

  task automatic compare_counters();
    int start;
    start  = errors;
    checks += 5;
    if (perf_reqs !== 32'(exp_reqs)) begin
      $display("Fail at %0t: perf_reqs expected %0d got %0d", $time, exp_reqs, perf_reqs);
      errors++;
    end
    if (perf_hits !== 32'(exp_hits)) begin
      $display("Fail at %0t: perf_hits expected %0d got %0d", $time, exp_hits, perf_hits);
      errors++;
    end
    if (perf_misses !== 32'(exp_misses)) begin
      $display("Fail at %0t: perf_misses expected %0d got %0d",
               $time, exp_misses, perf_misses);
      errors++;
    end
    if (perf_hits + perf_misses !== 32'(exp_reqs)) begin
      $display("Fail at %0t: perf_hits + perf_misses expected %0d got %0d",
               $time, exp_reqs, perf_hits + perf_misses);
      errors++;
    end
    if (i_dut.i_props.failures != 0) begin
      $display("%0d handshake assertions fired during the run", i_dut.i_props.failures);
      errors++;
    end
    report_test("compare_counters", 0, start);
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    rstn       = 1'b0;
    core_req   = 1'b0;
    core_addr  = '0;
    lfsr       = 16'd70;
    exp_reqs   = 0;
    exp_hits   = 0;
    exp_misses = 0;
    checks     = 0;
    errors     = 0;
    aborted    = 1'b0;
    foreach (model_valid[i]) begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end
    repeat (10) @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    fill_all_lines();
    if (!aborted) begin
      reread_resident();
    end
    if (!aborted) begin
      evict_same_index();
    end
    if (!aborted) begin
      random_fetches(300);
    end
    compare_counters();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/tb_mem_responder.sv ====
/* Refill memory model, word data is its byte address XOR data_xor.
   Serves one line request at a time with 0 to 3 idle cycles before each beat. */
`default_nettype none

module tb_mem_responder #(
  parameter logic [31:0] data_xor = 32'h0
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic              mem_req,
  input  logic [31:0]       mem_addr,
  output logic              mem_valid,
  output icache_pkg::word_t mem_data
);

  import icache_pkg::*;

  logic [15:0] lfsr;
  logic [31:0] base;
  int          gap;

  // Fibonacci LFSR, taps 16 14 13 11, output taken from bit 7
  function automatic int draw_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      r    = (r << 1) | int'(lfsr[7]);
    end
    return r;
  endfunction

  initial begin
    mem_valid = 1'b0;
    mem_data  = '0;
    lfsr      = 16'd70;
    forever begin
      @(negedge clk);
      if (rstn && mem_req) begin
        base = {mem_addr[31:4], 4'h0};
        for (int beat = 0; beat < words_per_line; beat++) begin
          gap = draw_bits(2);
          @(negedge clk);
          mem_valid = 1'b0;
          repeat (gap) @(negedge clk);
          mem_valid = 1'b1;
          mem_data  = (base + 32'(4 * beat)) ^ data_xor;
        end
        @(negedge clk);
        mem_valid = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/icache_properties.sv ====
/* Handshake assertions on the cache top level, attached by bind.
   failures counts the assertions that fired. */
`default_nettype none

module icache_properties (
  input logic clk,
  input logic rstn,
  input logic mem_req,
  input logic core_wait
);

  int unsigned failures = 0;

  // Refill request is a single-cycle pulse
  a_req_pulse: assert property (@(posedge clk) disable iff (!rstn) mem_req |=> !mem_req)
    else begin
      $error("mem_req high for two cycles in a row");
      failures++;
    end

  // Refill only while the fetch side is stalled
  a_req_in_wait: assert property (@(posedge clk) disable iff (!rstn) mem_req |-> core_wait)
    else begin
      $error("mem_req high while core_wait is low");
      failures++;
    end

  a_idle_after_reset: assert property (@(posedge clk) $rose(rstn) |-> !core_wait)
    else begin
      $error("core_wait high in the first cycle after reset");
      failures++;
    end

endmodule

bind icache_top icache_properties i_props (
  .clk      (clk),
  .rstn     (rstn),
  .mem_req  (mem_req),
  .core_wait(core_wait)
);

`default_nettype wire

// ==== logic/icache_top.sv ====
/* Direct-mapped instruction cache, one outstanding line refill at a time.
   lines is a power of two, at least 2; fetch address bits 1:0 are ignored. */
`default_nettype none

module icache_top #(
  parameter int lines = 16
) (
  input  logic                clk,
  input  logic                rstn,
  // Fetch side
  input  logic                core_req,
  input  logic [31:0]         core_addr,
  output logic                core_wait,
  output icache_pkg::word_t   core_out,
  // Refill side
  output logic                mem_req,
  output logic [31:0]         mem_addr,
  input  logic                mem_valid,
  input  icache_pkg::word_t   mem_data,
  // Counters
  output logic [31:0]         perf_reqs,
  output logic [31:0]         perf_hits,
  output logic [31:0]         perf_misses
);

  import icache_pkg::*;

  localparam int idx_w = $clog2(lines);

  fetch_req_t       req;
  line_addr_t       miss_line;
  logic [idx_w-1:0] tag_addr;
  logic [idx_w-1:0] data_addr;
  logic             tag_we;
  logic             data_we;
  line_addr_t       tag_wr;
  line_addr_t       tag_rd;
  line_t            data_wr;
  line_t            data_rd;
  line_t            fill_line;
  logic             fill_done;

  // Byte offset dropped
  assign req      = fetch_req_t'(core_addr[addr_w-1:2]);
  assign mem_addr = {miss_line, {offset_w{1'b0}}};

  // ========================================
  // Controller and refill
  // ========================================
  icache_ctrl #(.lines(lines)) i_ctrl (
    .clk        (clk),
    .rstn       (rstn),
    .core_req   (core_req),
    .req        (req),
    .core_wait  (core_wait),
    .core_out   (core_out),
    .tag_addr   (tag_addr),
    .tag_we     (tag_we),
    .tag_wr     (tag_wr),
    .tag_rd     (tag_rd),
    .data_addr  (data_addr),
    .data_we    (data_we),
    .data_wr    (data_wr),
    .data_rd    (data_rd),
    .fill_start (mem_req),
    .miss_line  (miss_line),
    .fill_line  (fill_line),
    .fill_done  (fill_done),
    .perf_reqs  (perf_reqs),
    .perf_hits  (perf_hits),
    .perf_misses(perf_misses)
  );

  icache_refill i_refill (
    .clk       (clk),
    .rstn      (rstn),
    .fill_start(mem_req),
    .mem_valid (mem_valid),
    .mem_data  (mem_data),
    .fill_line (fill_line),
    .fill_done (fill_done)
  );

  // ========================================
  // Tag and data arrays
  // ========================================
  icache_array #(.entry_t(line_addr_t), .depth(lines)) i_tag_array (
    .clk  (clk),
    .addr (tag_addr),
    .we   (tag_we),
    .wdata(tag_wr),
    .rdata(tag_rd)
  );

  icache_array #(.entry_t(line_t), .depth(lines)) i_data_array (
    .clk  (clk),
    .addr (data_addr),
    .we   (data_we),
    .wdata(data_wr),
    .rdata(data_rd)
  );

endmodule

`default_nettype wire

// ==== logic/icache_ctrl.sv ====
/* Controller for a direct-mapped read-only cache; lines must be a power of two, at least 2.
   A request is taken only in idle, and a refill is one line of four ascending beats. */
`default_nettype none

module icache_ctrl #(
  parameter int lines = 16
) (
  input  logic                       clk,
  input  logic                       rstn,
  // Fetch side
  input  logic                       core_req,
  input  icache_pkg::fetch_req_t     req,
  output logic                       core_wait,
  output icache_pkg::word_t          core_out,
  // Arrays
  output logic [$clog2(lines)-1:0]   tag_addr,
  output logic                       tag_we,
  output icache_pkg::line_addr_t     tag_wr,
  input  icache_pkg::line_addr_t     tag_rd,
  output logic [$clog2(lines)-1:0]   data_addr,
  output logic                       data_we,
  output icache_pkg::line_t          data_wr,
  input  icache_pkg::line_t          data_rd,
  // Refill
  output logic                       fill_start,
  output icache_pkg::line_addr_t     miss_line,
  input  icache_pkg::line_t          fill_line,
  input  logic                       fill_done,
  // Counters
  output logic [31:0]                perf_reqs,
  output logic [31:0]                perf_hits,
  output logic [31:0]                perf_misses
);

  import icache_pkg::*;

  localparam int idx_w = $clog2(lines);

  ctrl_state_t      state;
  ctrl_state_t      next_state;
  fetch_req_t       req_q;
  logic [lines-1:0] valid;
  logic [idx_w-1:0] req_idx;
  logic [idx_w-1:0] held_idx;
  logic [idx_w-1:0] array_idx;
  logic             accept;
  logic             hit;

  // ========================================
  // Address decode and tag check
  // ========================================
  assign accept   = (state == idle) && core_req;
  assign req_idx  = req.line[idx_w-1:0];
  assign held_idx = req_q.line[idx_w-1:0];

  // Arrays follow the live request in idle so the read lands in check
  assign array_idx = (state == idle) ? req_idx : held_idx;
  assign tag_addr  = array_idx;
  assign data_addr = array_idx;

  // Only reached with a valid line, so the tag alone decides
  assign hit = (tag_rd == req_q.line);

  assign core_wait = (state != idle);

  // Line write on refill
  assign tag_we    = (state == refill);
  assign data_we   = (state == refill);
  assign tag_wr    = req_q.line;
  assign data_wr   = fill_line;
  assign miss_line = req_q.line;

  // ========================================
  // State machine
  // ========================================
  always_comb begin
    next_state = state;
    case (state)
      idle: begin
        if (core_req) begin
          next_state = valid[req_idx] ? check : miss_wait;
        end
      end
      check: begin
        next_state = hit ? idle : miss_wait;
      end
      miss_wait: begin
        if (fill_done) begin
          next_state = refill;
        end
      end
      refill: begin
        next_state = idle;
      end
      default: begin
        next_state = idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  // One pulse on entry to miss_wait, doubles as mem_req
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      fill_start <= 1'b0;
    end else begin
      fill_start <= (next_state == miss_wait) && (state != miss_wait);
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      valid <= '0;
    end else if (state == refill) begin
      valid[held_idx] <= 1'b1;
    end
  end

  // ========================================
  // Request and response registers
  // ========================================
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (state == check && hit) begin
      core_out <= data_rd[req_q.word];
    end else if (state == refill) begin
      core_out <= fill_line[req_q.word];
    end
  end

  // ========================================
  // Performance counters
  // ========================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      perf_reqs   <= 32'd0;
      perf_hits   <= 32'd0;
      perf_misses <= 32'd0;
    end else begin
      if (accept) begin
        perf_reqs <= perf_reqs + 32'd1;
      end
      if (state == check && hit) begin
        perf_hits <= perf_hits + 32'd1;
      end
      // Counted when the line is written, not when it is detected
      if (state == refill) begin
        perf_misses <= perf_misses + 32'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/icache_refill.sv ====
/* Assembles four refill beats, lowest word first, into one cache line.
   fill_line is only meaningful from the fill_done pulse until the next beat. */
`default_nettype none

module icache_refill (
  input  logic                clk,
  input  logic                rstn,
  input  logic                fill_start,
  input  logic                mem_valid,
  input  icache_pkg::word_t   mem_data,
  output icache_pkg::line_t   fill_line,
  output logic                fill_done
);

  import icache_pkg::*;

  logic [1:0] beat_cnt;
  logic       last_beat;

  assign last_beat = (beat_cnt == 2'd3);

  // ========================================
  // Beat counter and end of line
  // ========================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      beat_cnt  <= 2'd0;
      fill_done <= 1'b0;
    end else begin
      fill_done <= 1'b0;
      if (fill_start) begin
        beat_cnt <= 2'd0;
      end else if (mem_valid) begin
        beat_cnt  <= beat_cnt + 2'd1;
        fill_done <= last_beat;
      end
    end
  end

  // ========================================
  // Line shift register
  // ========================================

  // New beat enters at the top and moves down,
  // so after four beats the first one is word 0
  always_ff @(posedge clk) begin
    if (mem_valid) begin
      fill_line <= {mem_data, fill_line[words_per_line-1:1]};
    end
  end

endmodule

`default_nettype wire

// ==== logic/icache_array.sv ====
/* Single-port array, one write or one read per cycle, read data one cycle later.
   No reset on contents, so validity has to be tracked by the user. */
`default_nettype none

module icache_array #(
  parameter type entry_t = logic [31:0],
  parameter int  depth   = 16
) (
  input  logic                     clk,
  input  logic [$clog2(depth)-1:0] addr,
  input  logic                     we,
  input  entry_t                   wdata,
  output entry_t                   rdata
);

  entry_t mem [depth];

  // ========================================
  // Storage
  // ========================================

  // Write has priority, rdata holds during a write
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end else begin
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// ==== logic/icache_pkg.sv ====
/* Address split and shared types for a 4-word line instruction cache.
   Byte addresses are 32 bits and the low two bits are ignored on fetch. */
`default_nettype none

package icache_pkg;

  // ========================================
  // Geometry
  // ========================================
  localparam int addr_w         = 32;
  localparam int word_w         = 32;
  localparam int words_per_line = 4;
  localparam int offset_w       = 4;

  // ========================================
  // Types
  // ========================================
  typedef logic [word_w-1:0] word_t;

  // Word 0 sits at the low end
  typedef word_t [words_per_line-1:0] line_t;

  // Full line address, kept as the tag
  typedef logic [addr_w-offset_w-1:0] line_addr_t;

  typedef logic [1:0] word_sel_t;

  typedef struct packed {
    line_addr_t line;
    word_sel_t  word;
  } fetch_req_t;

  typedef enum logic [1:0] {
    idle,
    check,
    miss_wait,
    refill
  } ctrl_state_t;

endpackage

`default_nettype wire
